// File: include/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// ==============================
// Core sizing
// ==============================

// AES-128 round count
`define AES_ROUNDS 10

// Start edge to done pulse, in clock cycles
`define AES_LATENCY 56

// Low counter field that steps in CTR mode
`define AES_CTR_WIDTH 32

`endif

// File: hdl/aes_pkg.sv
`default_nettype none

package aes_pkg;

	// ==============================
	// Types
	// ==============================

	// Byte 0 in bits 127:120, as in FIPS-197
	typedef logic [127:0] block_t;
	// One state column or one key word
	typedef logic [31:0] word_t;

	typedef enum logic {
		MODE_ECB = 1'b0,
		MODE_CTR = 1'b1
	} aes_mode_t;

	// One operation, sampled on go
	typedef struct packed {
		aes_mode_t mode;
		block_t    key;
		// Block that runs through the rounds
		block_t    cipher_in;
		// Data block, kept for the CTR XOR
		block_t    text;
	} aes_job_t;

	// Datapath controls, one set per cycle
	typedef struct packed {
		logic       load;
		logic [1:0] col;
		logic       key_step;
		logic       col_en;
		logic       first_round;
		logic       last_round;
	} dp_ctrl_t;

	// ==============================
	// GF(2^8) arithmetic
	// ==============================

	// Multiply by x, reduce by x^8+x^4+x^3+x+1
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Shift-and-add product
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] acc;
		p = a;
		acc = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
			begin
				acc = acc ^ p;
			end
			p = xtime(p);
		end
		return acc;
	endfunction

	// Inverse as a^254, zero maps to zero
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] sq;
		logic [7:0] acc;
		sq = a;
		acc = 8'h01;
		// Collect a^2 * a^4 * ... * a^128
		for (int i = 1; i < 8; i++)
		begin
			sq = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	// Forward S-box: inverse, then the affine map with 0x63
	function automatic logic [7:0] sbox(input logic [7:0] b);
		logic [7:0] x;
		x = gf_inv(b);
		return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]}
			^ {x[3:0], x[7:4]} ^ 8'h63;
	endfunction

	// Round constant, 01 for round 1 up to 36 for round 10
	function automatic logic [7:0] rcon(input logic [3:0] round);
		logic [7:0] rc;
		rc = 8'h01;
		for (int i = 1; i < 10; i++)
		begin
			if (i < round)
			begin
				rc = xtime(rc);
			end
		end
		return rc;
	endfunction

endpackage

`default_nettype wire

// File: hdl/aes_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_input_stage
(
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 start,
	input  wire                 disable_core,
	input  wire                 finish,
	input  wire aes_pkg::aes_mode_t mode,
	input  wire aes_pkg::block_t key,
	input  wire aes_pkg::block_t din,
	input  wire aes_pkg::block_t iv,
	input  wire                 advance,
	output aes_pkg::aes_job_t   job,
	output logic                go,
	output logic                busy
);

	aes_pkg::block_t ctr;
	// IV of the last counter load
	aes_pkg::block_t iv_last;
	aes_pkg::block_t ctr_now;
	logic            iv_changed;
	logic            ctr_step;

	// Start is taken only from idle, never together with an abort
	assign go = start && !busy && !disable_core;

	// ==============================
	// CTR counter
	// ==============================

	assign iv_changed = (iv != iv_last);
	// Step only after a finished CTR block
	assign ctr_step = advance && (job.mode == aes_pkg::MODE_CTR);

	// Counter value that includes a step due on this edge
	always_comb
	begin
		ctr_now = ctr;
		if (ctr_step)
		begin
			ctr_now = {ctr[127:`AES_CTR_WIDTH], ctr[`AES_CTR_WIDTH-1:0] + 1'b1};
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctr <= '0;
			iv_last <= '0;
		end
		else if (go && mode == aes_pkg::MODE_CTR && iv_changed)
		begin
			// New IV restarts the sequence
			ctr <= iv;
			iv_last <= iv;
		end
		else
		begin
			ctr <= ctr_now;
		end
	end

	// ==============================
	// Job capture and busy
	// ==============================

	always_ff @(posedge clk)
	begin
		if (go)
		begin
			job.mode <= mode;
			job.key <= key;
			job.text <= din;
			if (mode == aes_pkg::MODE_ECB)
				job.cipher_in <= din;
			else
				job.cipher_in <= iv_changed ? iv : ctr_now;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (disable_core)
			busy <= 1'b0;
		else if (go)
			busy <= 1'b1;
		else if (finish)
			busy <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hdl/aes_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_control_unit
(
	input  wire               clk,
	input  wire               rst_n,
	input  wire               go,
	input  wire               disable_core,
	output aes_pkg::dp_ctrl_t ctrl,
	output logic [3:0]        round,
	output logic              finish
);

	// ==============================
	// FSM states
	// ==============================

	typedef enum logic [3:0] {
		IDLE,
		ROUND0_COL0,
		ROUND0_COL1,
		ROUND0_COL2,
		ROUND0_COL3,
		ROUND_KEY,
		ROUND_COL0,
		ROUND_COL1,
		ROUND_COL2,
		ROUND_COL3,
		READY
	} state_t;

	state_t     state;
	state_t     next_state;
	logic [3:0] rd_count;
	logic       first_round;
	logic       last_round;

	assign first_round = (rd_count == 4'd0);
	assign last_round = (rd_count == 4'(`AES_ROUNDS));
	assign round = rd_count;

	// Abort wins over every transition
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else if (disable_core)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Round 0 is four columns, each later round a key step plus four columns
	always_comb
	begin
		next_state = state;
		unique case (state)
			IDLE:        next_state = go ? ROUND0_COL0 : IDLE;
			ROUND0_COL0: next_state = ROUND0_COL1;
			ROUND0_COL1: next_state = ROUND0_COL2;
			ROUND0_COL2: next_state = ROUND0_COL3;
			ROUND0_COL3: next_state = ROUND_KEY;
			ROUND_KEY:   next_state = ROUND_COL0;
			ROUND_COL0:  next_state = ROUND_COL1;
			ROUND_COL1:  next_state = ROUND_COL2;
			ROUND_COL2:  next_state = ROUND_COL3;
			ROUND_COL3:  next_state = last_round ? READY : ROUND_KEY;
			READY:       next_state = IDLE;
			default:     next_state = IDLE;
		endcase
	end

	// ==============================
	// Round counter
	// ==============================

	// Steps as a round closes, so ROUND_KEY already sees its own round
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= 4'd0;
		else if (disable_core || state == READY)
			rd_count <= 4'd0;
		else if (state == ROUND0_COL3 || (state == ROUND_COL3 && !last_round))
			rd_count <= rd_count + 4'd1;
	end

	// ==============================
	// Datapath controls
	// ==============================

	always_comb
	begin
		ctrl = '0;
		unique case (state)
			ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3:
			begin
				// Block and key come straight from the job
				ctrl.load = 1'b1;
				ctrl.col = 2'(state - ROUND0_COL0);
				ctrl.col_en = 1'b1;
				ctrl.first_round = first_round;
			end
			ROUND_KEY:
			begin
				ctrl.key_step = 1'b1;
			end
			ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
			begin
				ctrl.col = 2'(state - ROUND_COL0);
				ctrl.col_en = 1'b1;
				ctrl.last_round = last_round;
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

	// Single pulse out of READY, dropped on abort
	assign finish = (state == READY) && !disable_core;

endmodule

`default_nettype wire

// File: hdl/aes_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module aes_datapath
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire aes_pkg::aes_job_t job,
	input  wire aes_pkg::dp_ctrl_t ctrl,
	input  wire [3:0]              round,
	output aes_pkg::block_t        cipher_out
);

	// State, column 0 in the top word, kept in ShiftRows order
	aes_pkg::block_t         st;
	// Round key words, word 0 at index 0
	aes_pkg::word_t [3:0]    kw;
	aes_pkg::word_t          sbox_in;
	aes_pkg::word_t          sbox_out;
	aes_pkg::word_t          g_word;
	aes_pkg::word_t          key_new;
	aes_pkg::word_t          pre_ark;
	aes_pkg::word_t          col_out;

	// ==============================
	// Helpers
	// ==============================

	function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t w);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		{a0, a1, a2, a3} = w;
		return {
			aes_pkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
			aes_pkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
			aes_pkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
			aes_pkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2
		};
	endfunction

	// Row r moves left by r columns
	function automatic aes_pkg::block_t shift_rows(input aes_pkg::block_t b);
		aes_pkg::block_t s;
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				s[127 - 32*c - 8*r -: 8] = b[127 - 32*((c + r) % 4) - 8*r -: 8];
			end
		end
		return s;
	endfunction

	// ==============================
	// Column step
	// ==============================

	always_comb
	begin
		// Shared S-box, RotWord of key word 3 on a key step
		if (ctrl.key_step)
			sbox_in = {kw[3][23:0], kw[3][31:24]};
		else
			sbox_in = st[(3 - ctrl.col) * 32 +: 32];
		for (int i = 0; i < 4; i++)
		begin
			sbox_out[8*i +: 8] = aes_pkg::sbox(sbox_in[8*i +: 8]);
		end
		g_word = sbox_out ^ {aes_pkg::rcon(round), 24'h000000};

		// Word 0 is ready after the key step, the rest chain off the previous word
		if (ctrl.load)
			key_new = job.key[(3 - ctrl.col) * 32 +: 32];
		else if (ctrl.col == 2'd0)
			key_new = kw[0];
		else
			key_new = kw[ctrl.col] ^ kw[ctrl.col - 2'd1];

		// Round 0 adds the key only, last round skips MixColumns
		if (ctrl.first_round)
			pre_ark = job.cipher_in[(3 - ctrl.col) * 32 +: 32];
		else if (ctrl.last_round)
			pre_ark = sbox_out;
		else
			pre_ark = mix_col(sbox_out);
		col_out = pre_ark ^ key_new;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			st <= '0;
			kw <= '0;
		end
		else
		begin
			if (ctrl.key_step)
				kw[0] <= kw[0] ^ g_word;
			if (ctrl.col_en)
			begin
				kw[ctrl.col] <= key_new;
				// Closing column of a middle round, shift the whole state at once
				if (ctrl.col == 2'd3 && !ctrl.last_round)
					st <= shift_rows({st[127:32], col_out});
				else
					st[(3 - ctrl.col) * 32 +: 32] <= col_out;
			end
		end
	end

	assign cipher_out = st;

endmodule

`default_nettype wire

// File: hdl/aes_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module aes_output_stage
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    finish,
	input  wire aes_pkg::aes_job_t job,
	input  wire aes_pkg::block_t   cipher_out,
	output aes_pkg::block_t        dout,
	output logic                   done
);

	// ==============================
	// Result register
	// ==============================

	// dout holds until the next finish
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dout <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= finish;
			if (finish)
			begin
				// CTR output is keystream XOR data
				if (job.mode == aes_pkg::MODE_CTR)
					dout <= cipher_out ^ job.text;
				else
					dout <= cipher_out;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/aes_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_core
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     start,
	input  wire                     disable_core,
	input  wire aes_pkg::aes_mode_t mode,
	input  wire aes_pkg::block_t    key,
	input  wire aes_pkg::block_t    din,
	input  wire aes_pkg::block_t    iv,
	output aes_pkg::block_t         dout,
	output logic                    done,
	output logic                    busy
);

	aes_pkg::aes_job_t job;
	aes_pkg::dp_ctrl_t ctrl;
	aes_pkg::block_t   cipher_out;
	logic [3:0]        round;
	logic              go;
	logic              finish;

	// ==============================
	// Input side
	// ==============================

	// done doubles as the CTR advance
	aes_input_stage u_input
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.disable_core (disable_core),
		.finish       (finish),
		.mode         (mode),
		.key          (key),
		.din          (din),
		.iv           (iv),
		.advance      (done),
		.job          (job),
		.go           (go),
		.busy         (busy)
	);

	// ==============================
	// Processing
	// ==============================

	aes_control_unit u_control
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.go           (go),
		.disable_core (disable_core),
		.ctrl         (ctrl),
		.round        (round),
		.finish       (finish)
	);

	aes_datapath u_datapath
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.job        (job),
		.ctrl       (ctrl),
		.round      (round),
		.cipher_out (cipher_out)
	);

	// ==============================
	// Output side
	// ==============================

	aes_output_stage u_output
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.finish     (finish),
		.job        (job),
		.cipher_out (cipher_out),
		.dout       (dout),
		.done       (done)
	);

endmodule

`default_nettype wire

// File: sim/aes_core_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_core_props
(
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire disable_core,
	input wire busy,
	input wire done
);

	logic       accepted;
	// Cycles since the accepted start, zero when no run is live
	logic [6:0] run_age;

	// Same qualification as the input stage applies
	assign accepted = start && !busy && !disable_core;

	// ==============================
	// Run age tracker
	// ==============================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			run_age <= 7'd0;
		else if (disable_core)
			run_age <= 7'd0;
		else if (accepted)
			run_age <= 7'd1;
		else if (run_age != 7'd0 && run_age != 7'(`AES_LATENCY))
			run_age <= run_age + 7'd1;
		else
			run_age <= 7'd0;
	end

	// ==============================
	// Properties
	// ==============================

	// Done is a single-cycle pulse
	a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// No done without a live run of the full latency
	a_done_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (run_age == 7'(`AES_LATENCY)))
		else $error("done without an accepted start AES_LATENCY cycles earlier");

	// Unaborted run always ends in done
	a_run_gives_done: assert property (@(posedge clk) disable iff (!rst_n)
		(run_age == 7'(`AES_LATENCY)) |-> done)
		else $error("accepted start not followed by done after AES_LATENCY cycles");

	// Busy already dropped when the result shows
	a_busy_low_on_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !busy)
		else $error("busy high together with done");

endmodule

`default_nettype wire

// File: sim/aes_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_core_tb;

	// Margin past the latency before a missing done counts
	localparam int TIMEOUT = `AES_LATENCY + 20;

	logic               clk;
	logic               rst_n;
	logic               start;
	logic               disable_core;
	aes_pkg::aes_mode_t mode;
	aes_pkg::block_t    key;
	aes_pkg::block_t    din;
	aes_pkg::block_t    iv;
	aes_pkg::block_t    dout;
	logic               done;
	logic               busy;

	// Expected results in start order
	aes_pkg::block_t exp_q[$];
	int              errors = 0;
	int              timeouts = 0;
	int              checks = 0;
	// Results taken off the queue so far
	int              checked = 0;
	// CTR counter model
	aes_pkg::block_t ctr_model;

	aes_core dut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.disable_core (disable_core),
		.mode         (mode),
		.key          (key),
		.din          (din),
		.iv           (iv),
		.dout         (dout),
		.done         (done),
		.busy         (busy)
	);

	bind aes_core aes_core_props props
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.disable_core (disable_core),
		.busy         (busy),
		.done         (done)
	);

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// ==============================
	// Reference model
	// ==============================

	// FIPS-197 cipher with byte i of the state at row i%4 of column i/4
	function automatic aes_pkg::block_t aes128_ref(input aes_pkg::block_t k,
		input aes_pkg::block_t pt);
		logic [31:0]     w [44];
		logic [7:0]      s [16];
		logic [7:0]      t [16];
		logic [31:0]     tmp;
		aes_pkg::block_t res;
		for (int i = 0; i < 4; i++)
		begin
			w[i] = k[127 - 32*i -: 32];
		end
		// Key expansion with RotWord and SubWord on every fourth word
		for (int i = 4; i < 44; i++)
		begin
			tmp = w[i - 1];
			if (i % 4 == 0)
			begin
				tmp = {tmp[23:0], tmp[31:24]};
				tmp = {aes_pkg::sbox(tmp[31:24]), aes_pkg::sbox(tmp[23:16]),
					aes_pkg::sbox(tmp[15:8]), aes_pkg::sbox(tmp[7:0])};
				tmp[31:24] = tmp[31:24] ^ aes_pkg::rcon(4'(i / 4));
			end
			w[i] = w[i - 4] ^ tmp;
		end
		// Round 0 is AddRoundKey only
		for (int i = 0; i < 16; i++)
		begin
			s[i] = pt[127 - 8*i -: 8] ^ w[i / 4][31 - 8*(i % 4) -: 8];
		end
		for (int r = 1; r <= `AES_ROUNDS; r++)
		begin
			// SubBytes with ShiftRows folded into the read index
			for (int c = 0; c < 4; c++)
			begin
				for (int row = 0; row < 4; row++)
				begin
					t[4*c + row] = aes_pkg::sbox(s[4*((c + row) % 4) + row]);
				end
			end
			for (int c = 0; c < 4; c++)
			begin
				if (r < `AES_ROUNDS)
				begin
					// Rotated matrix rows of 2 3 1 1
					s[4*c] = aes_pkg::xtime(t[4*c]) ^ aes_pkg::xtime(t[4*c+1]) ^ t[4*c+1]
						^ t[4*c+2] ^ t[4*c+3];
					s[4*c+1] = t[4*c] ^ aes_pkg::xtime(t[4*c+1]) ^ aes_pkg::xtime(t[4*c+2])
						^ t[4*c+2] ^ t[4*c+3];
					s[4*c+2] = t[4*c] ^ t[4*c+1] ^ aes_pkg::xtime(t[4*c+2])
						^ aes_pkg::xtime(t[4*c+3]) ^ t[4*c+3];
					s[4*c+3] = aes_pkg::xtime(t[4*c]) ^ t[4*c] ^ t[4*c+1] ^ t[4*c+2]
						^ aes_pkg::xtime(t[4*c+3]);
				end
				else
				begin
					for (int row = 0; row < 4; row++)
					begin
						s[4*c + row] = t[4*c + row];
					end
				end
				for (int row = 0; row < 4; row++)
				begin
					s[4*c + row] = s[4*c + row] ^ w[4*r + c][31 - 8*row -: 8];
				end
			end
		end
		for (int i = 0; i < 16; i++)
		begin
			res[127 - 8*i -: 8] = s[i];
		end
		return res;
	endfunction

	// ==============================
	// Helpers
	// ==============================

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic aes_pkg::block_t rand_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// One-cycle start pulse with inputs set on the falling edge
	task automatic start_job(input aes_pkg::aes_mode_t m, input aes_pkg::block_t k,
		input aes_pkg::block_t d, input aes_pkg::block_t v);
		@(negedge clk);
		mode = m;
		key = k;
		din = d;
		iv = v;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Block until the compare process has taken result number target
	task automatic wait_checked(input int target);
		int n;
		n = 0;
		while (checked < target && n < 2 * TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (checked < target)
		begin
			timeouts++;
			$display("Timeout: result %0d was never compared", target);
		end
	endtask

	task automatic run_job(input aes_pkg::aes_mode_t m, input aes_pkg::block_t k,
		input aes_pkg::block_t d, input aes_pkg::block_t v, input aes_pkg::block_t exp);
		int target;
		exp_q.push_back(exp);
		target = checked + exp_q.size();
		start_job(m, k, d, v);
		wait_checked(target);
	endtask

	// ==============================
	// Compare process
	// ==============================

	// Checks dout on every done and flags a done with nothing pending
	initial
	begin : compare
		int n;
		forever
		begin
			@(negedge clk);
			if (exp_q.size() == 0)
			begin
				if (done === 1'b1)
				begin
					errors++;
					$display("Unexpected done pulse while no result was pending");
				end
			end
			else
			begin
				n = 0;
				while (done !== 1'b1 && n < TIMEOUT)
				begin
					@(negedge clk);
					n++;
				end
				if (done === 1'b1)
				begin
					check_value("dout", dout, exp_q.pop_front());
				end
				else
				begin
					timeouts++;
					$display("Timeout: no done within %0d cycles", TIMEOUT);
					void'(exp_q.pop_front());
				end
				checked++;
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	initial
	begin
		aes_pkg::block_t k;
		aes_pkg::block_t d;
		aes_pkg::block_t civ;
		aes_pkg::block_t kat;
		void'($urandom(32'h7fdf3ab7));
		rst_n = 1'b0;
		start = 1'b0;
		disable_core = 1'b0;
		mode = aes_pkg::MODE_ECB;
		key = '0;
		din = '0;
		iv = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Idle outputs after reset
		@(negedge clk);
		check_value("done", 128'(done), 128'd0);
		check_value("busy", 128'(busy), 128'd0);
		check_value("dout", dout, 128'd0);

		// FIPS-197 appendix C.1 vector that also checks the model itself
		k = 128'h000102030405060708090a0b0c0d0e0f;
		d = 128'h00112233445566778899aabbccddeeff;
		kat = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		check_value("aes128_ref", aes128_ref(k, d), kat);
		run_job(aes_pkg::MODE_ECB, k, d, iv, kat);

		// Random ECB
		for (int i = 0; i < 20; i++)
		begin
			k = rand_block();
			d = rand_block();
			run_job(aes_pkg::MODE_ECB, k, d, iv, aes128_ref(k, d));
		end

		// CTR with the low word near all ones so it wraps mid-sequence
		k = rand_block();
		civ = rand_block();
		civ[31:0] = 32'hfffffffb;
		ctr_model = civ;
		for (int i = 0; i < 8; i++)
		begin
			d = rand_block();
			run_job(aes_pkg::MODE_CTR, k, d, civ, d ^ aes128_ref(k, ctr_model));
			ctr_model[`AES_CTR_WIDTH-1:0] = ctr_model[`AES_CTR_WIDTH-1:0] + 1'b1;
		end

		// Second start lands in round 0 while key and block are still read
		k = rand_block();
		d = rand_block();
		exp_q.push_back(aes128_ref(k, d));
		start_job(aes_pkg::MODE_ECB, k, d, iv);
		check_value("busy", 128'(busy), 128'd1);
		start_job(aes_pkg::MODE_ECB, rand_block(), rand_block(), iv);
		wait_checked(checked + exp_q.size());
		// Room for a stray second done
		repeat (`AES_LATENCY + 5) @(negedge clk);

		// Abort mid-run with nothing coming out
		start_job(aes_pkg::MODE_ECB, rand_block(), rand_block(), iv);
		repeat (20) @(negedge clk);
		check_value("busy", 128'(busy), 128'd1);
		disable_core = 1'b1;
		@(negedge clk);
		disable_core = 1'b0;
		check_value("busy", 128'(busy), 128'd0);
		repeat (`AES_LATENCY + 5) @(negedge clk);

		// Core still works after the abort
		k = rand_block();
		d = rand_block();
		run_job(aes_pkg::MODE_ECB, k, d, iv, aes128_ref(k, d));

		repeat (5) @(negedge clk);
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: aes_core.f
+incdir+include
hdl/aes_pkg.sv
hdl/aes_input_stage.sv
hdl/aes_control_unit.sv
hdl/aes_datapath.sv
hdl/aes_output_stage.sv
hdl/aes_core.sv
sim/aes_core_props.sv
sim/aes_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AES core testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module aes_core_tb -Mdir obj_dir -o Vaes_core_tb -f aes_core.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vaes_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
	exit 0
fi
exit 1
